/* include/stream_defs.svh */
`ifndef STREAM_DEFS_SVH
`define STREAM_DEFS_SVH

// key and iv share one width
`define IV_WIDTH 80

// three shift registers of 93, 84 and 111 bits
`define STATE_WIDTH 288

// 4 x 288 single-bit rounds before any output
`define SETUP_ROUNDS 1152

// a power of two of at least 4
`define KS_FIFO_DEPTH 8

// fill count has to hold the full value too
`define KS_FIFO_CNT_W ($clog2(`KS_FIFO_DEPTH) + 1)

`endif

/* rtl/cipher_pkg.sv */
`include "stream_defs.svh"

package cipher_pkg;

    // core phase driven by the sequencer
    typedef enum logic [1:0] {
        IDLE  = 2'd0,   // reload from key/iv
        SETUP = 2'd1,   // warm-up at one bit per cycle
        GEN   = 2'd2    // one keystream byte per cycle
    } trivium_state_t;

    typedef struct packed {
        logic [`IV_WIDTH-1:0] key;
        logic [`IV_WIDTH-1:0] iv;
    } key_iv_t;

    typedef struct packed {
        logic [7:0] data;   // bit 0 is the first output bit
        logic       valid;
    } ks_byte_t;

    typedef struct packed {
        logic [7:0] data;
        logic       strobe;
    } pt_byte_t;

    typedef struct packed {
        logic [7:0] data;
        logic       valid;
    } ct_byte_t;

endpackage

/* rtl/ks_fifo.sv */
`include "stream_defs.svh"

module ks_fifo
    import cipher_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      flush,
    input  ks_byte_t                  push_data,
    input  logic                      pop,
    output logic [7:0]                head,
    output logic                      empty,
    output logic [`KS_FIFO_CNT_W-1:0] fill
);

    localparam int DEPTH = `KS_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = `KS_FIFO_CNT_W;

    localparam logic [CNT_W-1:0] FULL = CNT_W'(DEPTH);

    logic [7:0]       mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             do_push;
    logic             do_pop;

    // flush beats a push or pop on the same edge
    assign do_push = push_data.valid && !flush;
    assign do_pop  = pop && !flush;

    assign head  = mem[rd_ptr];
    assign empty = (fill == '0);

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;   // wraps since depth is a power of two
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    // stall from the sequencer must keep the core from overrunning us
    a_no_push_full: assert property (@(posedge clk) disable iff (rst)
        do_push |-> fill != FULL)
        else $error("ks_fifo: push while full");

    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
        do_pop |-> !empty)
        else $error("ks_fifo: pop while empty");

endmodule

/* rtl/ks_sequencer.sv */
`include "stream_defs.svh"

module ks_sequencer
    import cipher_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  key_iv_t                   key_iv_in,
    input  logic [`KS_FIFO_CNT_W-1:0] fill,
    output trivium_state_t            phase,
    output key_iv_t                   key_iv,
    output logic                      stall,
    output logic                      flush
);

    localparam int CNT_W  = $clog2(`SETUP_ROUNDS + 1);   // 11 bits
    localparam int FILL_W = `KS_FIFO_CNT_W;

    localparam logic [CNT_W-1:0]  LAST_ROUND  = CNT_W'(`SETUP_ROUNDS - 1);
    localparam logic [FILL_W-1:0] STALL_LEVEL = FILL_W'(`KS_FIFO_DEPTH - 1);

    logic [CNT_W-1:0] round_cnt;
    logic             restart;   // cycle after start when the core reloads

    assign flush = restart;

    // keep one slot free for the byte in the core output register
    assign stall = (fill >= STALL_LEVEL);

    always_ff @(posedge clk) begin
        if (start) begin
            key_iv <= key_iv_in;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            phase     <= IDLE;
            round_cnt <= '0;
            restart   <= 1'b0;
        end else begin
            restart <= start;
            if (start) begin
                phase     <= IDLE;
                round_cnt <= '0;
            end else if (restart) begin
                phase <= SETUP;
            end else if (phase == SETUP) begin
                if (round_cnt == LAST_ROUND) begin
                    phase     <= GEN;
                    round_cnt <= '0;
                end else begin
                    round_cnt <= round_cnt + 1'b1;
                end
            end
        end
    end

    a_round_cnt_range: assert property (@(posedge clk) disable iff (rst)
        round_cnt <= CNT_W'(`SETUP_ROUNDS))
        else $error("ks_sequencer: round counter past SETUP_ROUNDS");

endmodule

/* rtl/stream_cipher_top.sv */
`include "stream_defs.svh"

module stream_cipher_top
    import cipher_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     start,
    input  key_iv_t  key_iv,
    input  pt_byte_t pt,
    output logic     ready,
    output ct_byte_t ct
);

    trivium_state_t            phase;
    key_iv_t                   core_key_iv;
    logic                      stall;
    logic                      flush;
    ks_byte_t                  ks;
    logic [7:0]                head;
    logic                      empty;
    logic                      pop;
    logic [`KS_FIFO_CNT_W-1:0] fill;

    assign ready = !empty;

    ks_sequencer u_seq (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .key_iv_in (key_iv),
        .fill      (fill),
        .phase     (phase),
        .key_iv    (core_key_iv),
        .stall     (stall),
        .flush     (flush)
    );

    trivium u_core (
        .clk    (clk),
        .rst    (rst),
        .phase  (phase),
        .key_iv (core_key_iv),
        .stall  (stall),
        .ks     (ks)
    );

    ks_fifo u_fifo (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .push_data (ks),
        .pop       (pop),
        .head      (head),
        .empty     (empty),
        .fill      (fill)
    );

    stream_xor u_xor (
        .clk   (clk),
        .rst   (rst),
        .pt    (pt),
        .head  (head),
        .empty (empty),
        .pop   (pop),
        .ct    (ct)
    );

endmodule

/* rtl/stream_xor.sv */
module stream_xor
    import cipher_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  pt_byte_t   pt,
    input  logic [7:0] head,
    input  logic       empty,
    output logic       pop,
    output ct_byte_t   ct
);

    // head byte is used and released on the strobe cycle
    assign pop = pt.strobe;

    always_ff @(posedge clk) begin
        if (pt.strobe) begin
            ct.data <= pt.data ^ head;
        end
        if (rst) begin
            ct.valid <= 1'b0;
        end else begin
            ct.valid <= pt.strobe;
        end
    end

    // sender has to wait for ready at the top
    a_strobe_needs_ks: assert property (@(posedge clk) disable iff (rst)
        pt.strobe |-> !empty)
        else $error("stream_xor: plaintext strobe with no keystream buffered");

endmodule

/* rtl/trivium.sv */
`include "stream_defs.svh"

module trivium
    import cipher_pkg::*;
(
    input  logic           clk,
    input  logic           rst,
    input  trivium_state_t phase,
    input  key_iv_t        key_iv,
    input  logic           stall,
    output ks_byte_t       ks
);

    localparam int SW = `STATE_WIDTH;

    // register a is 92..0, b is 176..93, c is 287..177
    localparam int A_TOP = 92;
    localparam int B_LO  = 93;
    localparam int B_TOP = 176;
    localparam int C_LO  = 177;

    logic [SW-1:0] s_q;
    logic [SW-1:0] s_d;
    logic [SW-1:0] s_load;
    logic [7:0]    z;
    logic          hold;
    logic          gen_step;

    // one round with z_bit taken before the and-terms are folded in
    function automatic logic [SW-1:0] trivium_round(
        input  logic [SW-1:0] s,
        output logic          z_bit
    );
        logic t1;
        logic t2;
        logic t3;
        t1    = s[65] ^ s[92];
        t2    = s[161] ^ s[176];
        t3    = s[242] ^ s[287];
        z_bit = t1 ^ t2 ^ t3;
        t1    = t1 ^ (s[90] & s[91]) ^ s[170];
        t2    = t2 ^ (s[174] & s[175]) ^ s[263];
        t3    = t3 ^ (s[285] & s[286]) ^ s[68];
        // each register shifts up by one with feedback entering at the bottom
        return {s[SW-2:C_LO], t2, s[B_TOP-1:B_LO], t1, s[A_TOP-1:0], t3};
    endfunction

    // key low in a, iv low in b and three ones on top of c
    always_comb begin
        s_load                       = '0;
        s_load[`IV_WIDTH-1:0]        = key_iv.key;
        s_load[B_LO +: `IV_WIDTH]    = key_iv.iv;   // bit 173 stays zero
        s_load[SW-1:SW-3]            = 3'b111;
    end

    always_comb begin
        logic [SW-1:0] s;
        logic          z_bit;
        s     = s_q;
        z     = '0;
        z_bit = 1'b0;
        case (phase)
            SETUP: begin
                s = trivium_round(s, z_bit);   // output discarded in warm-up
            end
            GEN: begin
                for (int k = 0; k < 8; k++) begin
                    s    = trivium_round(s, z_bit);
                    z[k] = z_bit;
                end
            end
            default: begin
                s = s_load;
            end
        endcase
        s_d = s;
    end

    // stall only matters while producing bytes
    assign hold     = (phase == GEN) && stall;
    assign gen_step = (phase == GEN) && !stall;

    always_ff @(posedge clk) begin
        if (!hold) begin
            s_q <= s_d;
        end
    end

    always_ff @(posedge clk) begin
        ks.data <= z;
        if (rst) begin
            ks.valid <= 1'b0;
        end else begin
            ks.valid <= gen_step;
        end
    end

    // a fresh warm-up always goes through a reload
    a_gen_not_to_setup: assert property (@(posedge clk) disable iff (rst)
        phase == GEN |=> phase != SETUP)
        else $error("trivium: phase went from GEN to SETUP without IDLE");

endmodule

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_stream_cipher \
    -Mdir obj_dir -o sim_stream_cipher
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_stream_cipher)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qF 'All tests passed!'; then
    echo "result: PASS"
    exit 0
fi

echo "result: FAIL"
exit 1

/* verification/tb_stream_cipher.sv */
`include "stream_defs.svh"

module tb_stream_cipher
    import cipher_pkg::*;
;

    localparam int TIMEOUT_CYCLES = 8 * (`SETUP_ROUNDS + 100);

    logic     clk = 1'b0;
    logic     rst;
    logic     start;
    key_iv_t  key_iv;
    pt_byte_t pt;
    logic     ready;
    ct_byte_t ct;

    logic [31:0] rng;
    int          errors;
    int          checks;
    int          cycles;
    logic [7:0]  ks_ref [128];   // expected keystream of the current key

    stream_cipher_top uut (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .key_iv (key_iv),
        .pt     (pt),
        .ready  (ready),
        .ct     (ct)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lcg(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    // state bit in 1-based numbering
    function automatic logic sbit(input logic [`STATE_WIDTH-1:0] s, input int i);
        return s[i-1];
    endfunction

    // returns {z, next state}
    function automatic logic [`STATE_WIDTH:0] ref_round(input logic [`STATE_WIDTH-1:0] s);
        logic t1;
        logic t2;
        logic t3;
        logic z;
        logic [`STATE_WIDTH-1:0] n;
        t1 = sbit(s, 66) ^ sbit(s, 93);
        t2 = sbit(s, 162) ^ sbit(s, 177);
        t3 = sbit(s, 243) ^ sbit(s, 288);
        z  = t1 ^ t2 ^ t3;
        t1 = t1 ^ (sbit(s, 91) & sbit(s, 92)) ^ sbit(s, 171);
        t2 = t2 ^ (sbit(s, 175) & sbit(s, 176)) ^ sbit(s, 264);
        t3 = t3 ^ (sbit(s, 286) & sbit(s, 287)) ^ sbit(s, 69);
        n      = s << 1;   // s_i takes s_(i-1) everywhere
        n[0]   = t3;       // head of the first register
        n[93]  = t1;
        n[177] = t2;
        return {z, n};
    endfunction

    task automatic build_reference(input key_iv_t kiv, input int nbytes);
        logic [`STATE_WIDTH-1:0] s;
        logic [`STATE_WIDTH:0]   r;
        s = '0;
        s[`IV_WIDTH-1:0]   = kiv.key;
        s[93 +: `IV_WIDTH] = kiv.iv;
        s[287:285]         = 3'b111;
        for (int i = 0; i < `SETUP_ROUNDS; i++) begin
            r = ref_round(s);
            s = r[`STATE_WIDTH-1:0];
        end
        for (int b = 0; b < nbytes; b++) begin
            for (int k = 0; k < 8; k++) begin
                r = ref_round(s);
                ks_ref[b][k] = r[`STATE_WIDTH];   // first bit lands in bit 0
                s = r[`STATE_WIDTH-1:0];
            end
        end
    endtask

    task automatic next_byte(output logic [7:0] b);
        rng = lcg(rng);
        b = rng[23:16];
    endtask

    task automatic rand_key_iv(output key_iv_t kiv);
        for (int i = 0; i < 5; i++) begin
            rng = lcg(rng);
            kiv.key[16*i +: 16] = rng[31:16];
            rng = lcg(rng);
            kiv.iv[16*i +: 16] = rng[31:16];
        end
    endtask

    task automatic check_ct(input ct_byte_t got, input ct_byte_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s got data=%02h valid=%b, expected data=%02h valid=%b",
                $time, what, got.data, got.valid, exp.data, exp.valid);
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_latency(input int got, input int exp, input string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("[FAIL] %0t: %s took %0d cycles, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - err_before);
        end
    endtask

    // runs from a falling edge to the falling edge where ready is seen
    task automatic start_stream(input key_iv_t kiv, output int latency);
        key_iv = kiv;
        start  = 1'b1;
        @(negedge clk);
        start   = 1'b0;
        latency = 0;
        @(negedge clk);
        latency = 1;
        check_level(ready, 1'b0, "ready after flush");
        while (!ready) begin
            @(negedge clk);
            latency++;
        end
    endtask

    task automatic send_byte(input logic [7:0] data, input logic [7:0] exp_ct,
                             output logic [7:0] got, input string what);
        ct_byte_t exp;
        while (!ready) @(negedge clk);
        pt.data   = data;
        pt.strobe = 1'b1;
        @(negedge clk);
        pt.strobe = 1'b0;
        exp.data  = exp_ct;
        exp.valid = 1'b1;
        check_ct(ct, exp, what);
        got = ct.data;
    endtask

    task automatic test_reset_state();
        int err0;
        err0 = errors;
        check_level(ready, 1'b0, "ready after reset");
        check_level(ct.valid, 1'b0, "ct.valid after reset");
        repeat (20) begin
            @(negedge clk);
            check_level(ready, 1'b0, "ready before first start");
        end
        report_test("reset state", err0);
    endtask

    task automatic test_zero_key();
        int         err0;
        int         lat;
        key_iv_t    kiv;
        logic [7:0] got;
        err0 = errors;
        kiv  = '0;
        build_reference(kiv, 32);
        start_stream(kiv, lat);
        check_latency(lat, `SETUP_ROUNDS + 3, "first zero key byte");
        for (int i = 0; i < 32; i++) begin
            send_byte(8'h00, ks_ref[i], got, "zero key keystream byte");
        end
        report_test("zero key keystream", err0);
    endtask

    task automatic test_random_plaintext();
        int         err0;
        int         lat;
        key_iv_t    kiv;
        logic [7:0] p;
        logic [7:0] got;
        err0 = errors;
        rand_key_iv(kiv);
        build_reference(kiv, 104);   // test 4 keeps reading this stream
        start_stream(kiv, lat);
        check_latency(lat, `SETUP_ROUNDS + 3, "first keystream byte");
        for (int i = 0; i < 64; i++) begin
            next_byte(p);
            send_byte(p, p ^ ks_ref[i], got, "random plaintext ciphertext");
        end
        report_test("random plaintext", err0);
    endtask

    task automatic test_back_pressure();
        int         err0;
        logic [7:0] p;
        logic [7:0] got;
        err0 = errors;
        repeat (50) @(negedge clk);   // fifo fills and the core stalls
        check_level(ready, 1'b1, "ready with full fifo");
        for (int i = 64; i < 104; i++) begin
            next_byte(p);
            send_byte(p, p ^ ks_ref[i], got, "ciphertext after stall");
        end
        report_test("back-pressure", err0);
    endtask

    task automatic test_rekey();
        int         err0;
        int         lat;
        key_iv_t    kiv;
        logic [7:0] plain_buf [16];
        logic [7:0] cipher_buf [16];
        logic [7:0] got;
        err0 = errors;
        rand_key_iv(kiv);
        build_reference(kiv, 16);
        start_stream(kiv, lat);   // old bytes still buffered here
        check_latency(lat, `SETUP_ROUNDS + 3, "first byte after rekey");
        for (int i = 0; i < 16; i++) begin
            next_byte(plain_buf[i]);
            send_byte(plain_buf[i], plain_buf[i] ^ ks_ref[i], cipher_buf[i],
                "ciphertext after rekey");
        end
        start_stream(kiv, lat);
        check_latency(lat, `SETUP_ROUNDS + 3, "first byte after restart");
        for (int i = 0; i < 16; i++) begin
            send_byte(cipher_buf[i], plain_buf[i], got, "decrypted plaintext");
        end
        report_test("rekey mid-stream", err0);
    endtask

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run stopped after %0d cycles without finishing", cycles);
        $display("Test failures found");
        $finish;
    end

    initial begin
        rst    = 1'b1;
        start  = 1'b0;
        key_iv = '0;
        pt     = '0;
        rng    = 32'd58;
        errors = 0;
        checks = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_reset_state();
        test_zero_key();
        test_random_plaintext();
        test_back_pressure();
        test_rekey();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+include
rtl/cipher_pkg.sv
rtl/trivium.sv
rtl/ks_sequencer.sv
rtl/ks_fifo.sv
rtl/stream_xor.sv
rtl/stream_cipher_top.sv
verification/tb_stream_cipher.sv
